// ==== axi_channel_slice.sv ====
`timescale 1ns/1ps

module axi_channel_slice import glay_axi_pkg::*; #(
  parameter int payload_w = 8                  // packed channel fields
) (
  input  logic                 ap_clk,
  input  logic                 rst_n,
  input  logic                 in_valid,         // upstream beat present
  output logic                 in_ready,         // registered, no path from out_ready
  input  logic [payload_w-1:0] in_payload,
  output logic                 out_valid,        // registered
  input  logic                 out_ready,        // downstream accepts
  output logic [payload_w-1:0] out_payload       // straight from main register
);

  // ------------------------------
  // handshakes and occupancy
  // ------------------------------
  slice_state_t         state_q;           // current occupancy
  slice_state_t         state_d;           // occupancy after this edge
  logic                 in_fire;           // beat accepted at the input
  logic                 out_fire;          // beat taken at the output
  logic                 load_main;         // main takes the input beat
  logic                 main_from_spare;   // spare moves up into main
  logic                 load_spare;        // skid beat lands in spare
  logic [payload_w-1:0] main_q;            // beat shown at the output
  logic [payload_w-1:0] spare_q;           // beat caught while output stalls

  assign in_fire  = in_valid & in_ready;
  assign out_fire = out_valid & out_ready;

  always_comb begin
    state_d         = state_q;             // hold by default
    load_main       = 1'b0;
    main_from_spare = 1'b0;
    load_spare      = 1'b0;
    unique case (state_q)
      slice_empty: begin
        if (in_fire) begin
          state_d   = slice_one;           // first beat goes straight to main
          load_main = 1'b1;
        end
      end
      slice_one: begin
        if (in_fire && !out_fire) begin
          state_d    = slice_two;          // output stalled, park beat in spare
          load_spare = 1'b1;
        end else if (in_fire && out_fire) begin
          load_main = 1'b1;                // full rate, main replaced in place
        end else if (out_fire) begin
          state_d = slice_empty;           // drained
        end
      end
      slice_two: begin
        if (out_fire) begin
          state_d         = slice_one;     // in_ready is low here, no new beat
          main_from_spare = 1'b1;
        end
      end
      default: begin
        state_d = slice_empty;
      end
    endcase
  end

  // ------------------------------
  // control flops
  // ------------------------------
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= slice_empty;
      in_ready  <= 1'b0;                   // quiet during reset, high one edge later
      out_valid <= 1'b0;
    end else begin
      state_q   <= state_d;
      in_ready  <= (state_d != slice_two); // drop as soon as both entries fill
      out_valid <= (state_d != slice_empty);
    end
  end

  // ------------------------------
  // payload registers
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (load_main) begin
      main_q <= in_payload;
    end else if (main_from_spare) begin
      main_q <= spare_q;                   // keeps beat order
    end
    if (load_spare) begin
      spare_q <= in_payload;
    end
  end

  assign out_payload = main_q;

endmodule : axi_channel_slice

// ==== axi_read_slice.sv ====
`timescale 1ns/1ps

module axi_read_slice import glay_axi_pkg::*; (
  input  logic       ap_clk,
  input  logic       rst_n,
  // slave ar
  input  logic       s_arvalid,
  input  axi_id_t    s_arid,
  input  axi_addr_t  s_araddr,
  input  axi_len_t   s_arlen,
  input  axi_size_t  s_arsize,
  input  axi_burst_t s_arburst,
  output logic       s_arready,
  // slave r
  output logic       s_rvalid,
  output axi_id_t    s_rid,
  output axi_data_t  s_rdata,
  output axi_resp_t  s_rresp,
  output logic       s_rlast,
  input  logic       s_rready,
  // master ar
  output logic       m_arvalid,
  output axi_id_t    m_arid,
  output axi_addr_t  m_araddr,
  output axi_len_t   m_arlen,
  output axi_size_t  m_arsize,
  output axi_burst_t m_arburst,
  input  logic       m_arready,
  // master r
  input  logic       m_rvalid,
  input  axi_id_t    m_rid,
  input  axi_data_t  m_rdata,
  input  axi_resp_t  m_rresp,
  input  logic       m_rlast,
  output logic       m_rready
);

  // ------------------------------
  // packed channel vectors
  // ------------------------------
  localparam int ar_w = $bits(axi_id_t) + $bits(axi_addr_t) + $bits(axi_len_t) +
                        $bits(axi_size_t) + $bits(axi_burst_t);
  localparam int r_w  = $bits(axi_id_t) + $bits(axi_data_t) + $bits(axi_resp_t) + 1;

  logic [ar_w-1:0] ar_in;   // slave side, into the slice
  logic [ar_w-1:0] ar_out;  // master side, out of the slice
  logic [r_w-1:0]  r_in;    // master side
  logic [r_w-1:0]  r_out;   // slave side

  assign ar_in = {s_arid, s_araddr, s_arlen, s_arsize, s_arburst};
  assign {m_arid, m_araddr, m_arlen, m_arsize, m_arburst} = ar_out;

  assign r_in = {m_rid, m_rdata, m_rresp, m_rlast};
  assign {s_rid, s_rdata, s_rresp, s_rlast} = r_out;

  // forward, slave to master
  axi_channel_slice #(.payload_w(ar_w)) ar_slice (
    .ap_clk     (ap_clk),
    .rst_n      (rst_n),
    .in_valid   (s_arvalid),
    .in_ready   (s_arready),
    .in_payload (ar_in),
    .out_valid  (m_arvalid),
    .out_ready  (m_arready),
    .out_payload(ar_out)
  );

  // backward, master to slave
  axi_channel_slice #(.payload_w(r_w)) r_slice (
    .ap_clk     (ap_clk),
    .rst_n      (rst_n),
    .in_valid   (m_rvalid),
    .in_ready   (m_rready),
    .in_payload (r_in),
    .out_valid  (s_rvalid),
    .out_ready  (s_rready),
    .out_payload(r_out)
  );

endmodule : axi_read_slice

// ==== axi_register_slice_mid_end.sv ====
`timescale 1ns/1ps

module axi_register_slice_mid_end import glay_axi_pkg::*; (
  input  logic       ap_clk,
  input  logic       rst_n,       // async assert, released through two flops
  // slave read
  input  logic       s_arvalid,
  input  axi_id_t    s_arid,
  input  axi_addr_t  s_araddr,
  input  axi_len_t   s_arlen,
  input  axi_size_t  s_arsize,
  input  axi_burst_t s_arburst,
  output logic       s_arready,
  output logic       s_rvalid,
  output axi_id_t    s_rid,
  output axi_data_t  s_rdata,
  output axi_resp_t  s_rresp,
  output logic       s_rlast,
  input  logic       s_rready,
  // slave write
  input  logic       s_awvalid,
  input  axi_id_t    s_awid,
  input  axi_addr_t  s_awaddr,
  input  axi_len_t   s_awlen,
  input  axi_size_t  s_awsize,
  input  axi_burst_t s_awburst,
  output logic       s_awready,
  input  logic       s_wvalid,
  input  axi_data_t  s_wdata,
  input  axi_strb_t  s_wstrb,
  input  logic       s_wlast,
  output logic       s_wready,
  output logic       s_bvalid,
  output axi_id_t    s_bid,
  output axi_resp_t  s_bresp,
  input  logic       s_bready,
  // master read
  output logic       m_arvalid,
  output axi_id_t    m_arid,
  output axi_addr_t  m_araddr,
  output axi_len_t   m_arlen,
  output axi_size_t  m_arsize,
  output axi_burst_t m_arburst,
  input  logic       m_arready,
  input  logic       m_rvalid,
  input  axi_id_t    m_rid,
  input  axi_data_t  m_rdata,
  input  axi_resp_t  m_rresp,
  input  logic       m_rlast,
  output logic       m_rready,
  // master write
  output logic       m_awvalid,
  output axi_id_t    m_awid,
  output axi_addr_t  m_awaddr,
  output axi_len_t   m_awlen,
  output axi_size_t  m_awsize,
  output axi_burst_t m_awburst,
  input  logic       m_awready,
  output logic       m_wvalid,
  output axi_data_t  m_wdata,
  output axi_strb_t  m_wstrb,
  output logic       m_wlast,
  input  logic       m_wready,
  input  logic       m_bvalid,
  input  axi_id_t    m_bid,
  input  axi_resp_t  m_bresp,
  output logic       m_bready
);

  // ------------------------------
  // local reset for the slices
  // ------------------------------
  logic rst_meta_q;   // first stage, may go metastable on release
  logic slice_rst_n;  // second stage, feeds both paths

  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      rst_meta_q  <= 1'b0;
      slice_rst_n <= 1'b0;
    end else begin
      rst_meta_q  <= 1'b1;
      slice_rst_n <= rst_meta_q;  // high on second edge after release
    end
  end

  // ------------------------------
  // read path, ar and r
  // ------------------------------
  axi_read_slice u_read (
    .ap_clk   (ap_clk),
    .rst_n    (slice_rst_n),
    .s_arvalid(s_arvalid),
    .s_arid   (s_arid),
    .s_araddr (s_araddr),
    .s_arlen  (s_arlen),
    .s_arsize (s_arsize),
    .s_arburst(s_arburst),
    .s_arready(s_arready),
    .s_rvalid (s_rvalid),
    .s_rid    (s_rid),
    .s_rdata  (s_rdata),
    .s_rresp  (s_rresp),
    .s_rlast  (s_rlast),
    .s_rready (s_rready),
    .m_arvalid(m_arvalid),
    .m_arid   (m_arid),
    .m_araddr (m_araddr),
    .m_arlen  (m_arlen),
    .m_arsize (m_arsize),
    .m_arburst(m_arburst),
    .m_arready(m_arready),
    .m_rvalid (m_rvalid),
    .m_rid    (m_rid),
    .m_rdata  (m_rdata),
    .m_rresp  (m_rresp),
    .m_rlast  (m_rlast),
    .m_rready (m_rready)
  );

  // ------------------------------
  // write path, aw, w and b
  // ------------------------------
  axi_write_slice u_write (
    .ap_clk   (ap_clk),
    .rst_n    (slice_rst_n),
    .s_awvalid(s_awvalid),
    .s_awid   (s_awid),
    .s_awaddr (s_awaddr),
    .s_awlen  (s_awlen),
    .s_awsize (s_awsize),
    .s_awburst(s_awburst),
    .s_awready(s_awready),
    .s_wvalid (s_wvalid),
    .s_wdata  (s_wdata),
    .s_wstrb  (s_wstrb),
    .s_wlast  (s_wlast),
    .s_wready (s_wready),
    .s_bvalid (s_bvalid),
    .s_bid    (s_bid),
    .s_bresp  (s_bresp),
    .s_bready (s_bready),
    .m_awvalid(m_awvalid),
    .m_awid   (m_awid),
    .m_awaddr (m_awaddr),
    .m_awlen  (m_awlen),
    .m_awsize (m_awsize),
    .m_awburst(m_awburst),
    .m_awready(m_awready),
    .m_wvalid (m_wvalid),
    .m_wdata  (m_wdata),
    .m_wstrb  (m_wstrb),
    .m_wlast  (m_wlast),
    .m_wready (m_wready),
    .m_bvalid (m_bvalid),
    .m_bid    (m_bid),
    .m_bresp  (m_bresp),
    .m_bready (m_bready)
  );

endmodule : axi_register_slice_mid_end

// ==== axi_write_slice.sv ====
`timescale 1ns/1ps

module axi_write_slice import glay_axi_pkg::*; (
  input  logic       ap_clk,
  input  logic       rst_n,
  // slave aw
  input  logic       s_awvalid,
  input  axi_id_t    s_awid,
  input  axi_addr_t  s_awaddr,
  input  axi_len_t   s_awlen,
  input  axi_size_t  s_awsize,
  input  axi_burst_t s_awburst,
  output logic       s_awready,
  // slave w
  input  logic       s_wvalid,
  input  axi_data_t  s_wdata,
  input  axi_strb_t  s_wstrb,
  input  logic       s_wlast,
  output logic       s_wready,
  // slave b
  output logic       s_bvalid,
  output axi_id_t    s_bid,
  output axi_resp_t  s_bresp,
  input  logic       s_bready,
  // master aw
  output logic       m_awvalid,
  output axi_id_t    m_awid,
  output axi_addr_t  m_awaddr,
  output axi_len_t   m_awlen,
  output axi_size_t  m_awsize,
  output axi_burst_t m_awburst,
  input  logic       m_awready,
  // master w
  output logic       m_wvalid,
  output axi_data_t  m_wdata,
  output axi_strb_t  m_wstrb,
  output logic       m_wlast,
  input  logic       m_wready,
  // master b
  input  logic       m_bvalid,
  input  axi_id_t    m_bid,
  input  axi_resp_t  m_bresp,
  output logic       m_bready
);

  // ------------------------------
  // packed channel vectors
  // ------------------------------
  localparam int aw_w = $bits(axi_id_t) + $bits(axi_addr_t) + $bits(axi_len_t) +
                        $bits(axi_size_t) + $bits(axi_burst_t);
  localparam int w_w  = $bits(axi_data_t) + $bits(axi_strb_t) + 1;  // data, strb, last
  localparam int b_w  = $bits(axi_id_t) + $bits(axi_resp_t);

  logic [aw_w-1:0] aw_in;
  logic [aw_w-1:0] aw_out;
  logic [w_w-1:0]  w_in;
  logic [w_w-1:0]  w_out;
  logic [b_w-1:0]  b_in;    // from master side
  logic [b_w-1:0]  b_out;   // to slave side

  assign aw_in = {s_awid, s_awaddr, s_awlen, s_awsize, s_awburst};
  assign {m_awid, m_awaddr, m_awlen, m_awsize, m_awburst} = aw_out;

  assign w_in = {s_wdata, s_wstrb, s_wlast};
  assign {m_wdata, m_wstrb, m_wlast} = w_out;

  assign b_in = {m_bid, m_bresp};
  assign {s_bid, s_bresp} = b_out;

  axi_channel_slice #(.payload_w(aw_w)) aw_slice (
    .ap_clk     (ap_clk),
    .rst_n      (rst_n),
    .in_valid   (s_awvalid),
    .in_ready   (s_awready),
    .in_payload (aw_in),
    .out_valid  (m_awvalid),
    .out_ready  (m_awready),
    .out_payload(aw_out)
  );

  // data beats, not tied to aw order here
  axi_channel_slice #(.payload_w(w_w)) w_slice (
    .ap_clk     (ap_clk),
    .rst_n      (rst_n),
    .in_valid   (s_wvalid),
    .in_ready   (s_wready),
    .in_payload (w_in),
    .out_valid  (m_wvalid),
    .out_ready  (m_wready),
    .out_payload(w_out)
  );

  // response runs master to slave
  axi_channel_slice #(.payload_w(b_w)) b_slice (
    .ap_clk     (ap_clk),
    .rst_n      (rst_n),
    .in_valid   (m_bvalid),
    .in_ready   (m_bready),
    .in_payload (b_in),
    .out_valid  (s_bvalid),
    .out_ready  (s_bready),
    .out_payload(b_out)
  );

endmodule : axi_write_slice

// ==== flist.f ====
+incdir+.
glay_axi_pkg.sv
axi_channel_slice.sv
axi_read_slice.sv
axi_write_slice.sv
axi_register_slice_mid_end.sv
tb_axi_register_slice.sv

// ==== glay_axi_defines.svh ====
`ifndef GLAY_AXI_DEFINES_SVH
`define GLAY_AXI_DEFINES_SVH

// ------------------------------
// axi4 field widths
// ------------------------------

// byte address into the overlay memory space
`define GLAY_AXI_ADDR_W 32

// one beat on the memory port, eight bytes
`define GLAY_AXI_DATA_W 64

// transaction id, enough for the engines behind one port
`define GLAY_AXI_ID_W 4

// axi4 burst length field, beats minus one
`define GLAY_AXI_LEN_W 8

`endif

// ==== glay_axi_pkg.sv ====
`include "glay_axi_defines.svh"

package glay_axi_pkg;

  // ------------------------------
  // axi4 channel fields
  // ------------------------------
  typedef logic [`GLAY_AXI_ADDR_W-1:0]   axi_addr_t;  // byte address
  typedef logic [`GLAY_AXI_DATA_W-1:0]   axi_data_t;  // one data beat
  typedef logic [`GLAY_AXI_DATA_W/8-1:0] axi_strb_t;  // one strobe per data byte
  typedef logic [`GLAY_AXI_ID_W-1:0]     axi_id_t;    // transaction id
  typedef logic [`GLAY_AXI_LEN_W-1:0]    axi_len_t;   // beats minus one
  typedef logic [2:0]                    axi_size_t;  // log2 of bytes per beat
  typedef logic [1:0]                    axi_burst_t; // fixed, incr or wrap
  typedef logic [1:0]                    axi_resp_t;  // okay, exokay, slverr, decerr

  // ------------------------------
  // channel slice occupancy
  // ------------------------------
  typedef enum logic [1:0] {
    slice_empty, // nothing held, output idle
    slice_one,   // main register valid
    slice_two    // main and spare valid, input stalled
  } slice_state_t;

endpackage : glay_axi_pkg

// ==== tb_axi_register_slice.sv ====
`timescale 1ns/1ps

module tb_axi_register_slice import glay_axi_pkg::*; ();

  localparam int ch_ar = 0;
  localparam int ch_aw = 1;
  localparam int ch_w  = 2;
  localparam int ch_r  = 3;
  localparam int ch_b  = 4;
  localparam int ring  = 64;               // scoreboard depth per channel

  logic ap_clk = 1'b0;
  logic rst_n;
  logic s_arvalid, s_arready, s_rvalid, s_rlast, s_rready;
  logic s_awvalid, s_awready, s_wvalid, s_wlast, s_wready, s_bvalid, s_bready;
  logic m_arvalid, m_arready, m_rvalid, m_rlast, m_rready;
  logic m_awvalid, m_awready, m_wvalid, m_wlast, m_wready, m_bvalid, m_bready;
  axi_id_t    s_arid, s_rid, s_awid, s_bid, m_arid, m_rid, m_awid, m_bid;
  axi_addr_t  s_araddr, s_awaddr, m_araddr, m_awaddr;
  axi_len_t   s_arlen, s_awlen, m_arlen, m_awlen;
  axi_size_t  s_arsize, s_awsize, m_arsize, m_awsize;
  axi_burst_t s_arburst, s_awburst, m_arburst, m_awburst;
  axi_data_t  s_rdata, s_wdata, m_rdata, m_wdata;
  axi_strb_t  s_wstrb, m_wstrb;
  axi_resp_t  s_rresp, s_bresp, m_rresp, m_bresp;

  axi_register_slice_mid_end dut (.*);

  always #5 ap_clk = ~ap_clk;              // 10 ns period

  // per channel view indexed by ch_*
  logic [4:0] in_vld, in_rdy, out_vld, out_rdy;
  assign in_vld  = {m_bvalid, m_rvalid, s_wvalid, s_awvalid, s_arvalid};
  assign in_rdy  = {m_bready, m_rready, s_wready, s_awready, s_arready};
  assign out_vld = {s_bvalid, s_rvalid, m_wvalid, m_awvalid, m_arvalid};
  assign out_rdy = {s_bready, s_rready, m_wready, m_awready, m_arready};

  // ------------------------------
  // stimulus table
  // ------------------------------
  string       t_name [0:15];
  int          t_chan [0:15];
  int          t_beats[0:15];
  logic [63:0] t_base [0:15];
  int          t_mode [0:15];              // 0 ready high, 1 lfsr, 2 held low
  int          n_tests = 0;

  logic [127:0] exp_val [0:4][0:ring-1];   // expected beats in accept order
  int           exp_cyc [0:4][0:ring-1];   // cycle of the input handshake
  int           exp_tst [0:4][0:ring-1];   // owning test for error lines
  int           wr_ptr[0:4], rd_ptr[0:4];
  int           out_cnt[0:4], first_out[0:4], last_out[0:4];
  int           rdy_mode[0:4];
  int           cycle = 0;
  int           errors = 0;
  int           compared = 0;
  int           t_cur = 0;                 // test being applied
  logic [31:0]  lfsr = 32'h133f9a39;

  task automatic add_test(input string name, input int chan, input int beats,
                          input logic [63:0] base, input int mode);
    t_name[n_tests]  = name;
    t_chan[n_tests]  = chan;
    t_beats[n_tests] = beats;
    t_base[n_tests]  = base;
    t_mode[n_tests]  = mode;
    n_tests++;
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic string chan_name(input int ch);
    case (ch)
      ch_ar:   return "ar";
      ch_aw:   return "aw";
      ch_w:    return "w";
      ch_r:    return "r";
      default: return "b";
    endcase
  endfunction

  function automatic logic [127:0] in_payload(input int ch);
    case (ch)
      ch_ar:   return {s_arid, s_araddr, s_arlen, s_arsize, s_arburst};
      ch_aw:   return {s_awid, s_awaddr, s_awlen, s_awsize, s_awburst};
      ch_w:    return {s_wdata, s_wstrb, s_wlast};
      ch_r:    return {m_rid, m_rdata, m_rresp, m_rlast};
      default: return {m_bid, m_bresp};
    endcase
  endfunction

  function automatic logic [127:0] out_payload(input int ch);
    case (ch)
      ch_ar:   return {m_arid, m_araddr, m_arlen, m_arsize, m_arburst};
      ch_aw:   return {m_awid, m_awaddr, m_awlen, m_awsize, m_awburst};
      ch_w:    return {m_wdata, m_wstrb, m_wlast};
      ch_r:    return {s_rid, s_rdata, s_rresp, s_rlast};
      default: return {s_bid, s_bresp};
    endcase
  endfunction

  // called right after a rising edge
  task automatic drive_input(input int ch, input logic vld, input logic [63:0] v,
                             input logic last);
    case (ch)
      ch_ar: begin
        s_arvalid <= vld;
        s_arid    <= v[3:0];
        s_araddr  <= v[47:16];
        s_arlen   <= v[15:8];
        s_arsize  <= v[6:4];
        s_arburst <= v[58:57];
      end
      ch_aw: begin
        s_awvalid <= vld;
        s_awid    <= v[7:4];
        s_awaddr  <= v[63:32];
        s_awlen   <= v[23:16];
        s_awsize  <= v[2:0];
        s_awburst <= v[9:8];
      end
      ch_w: begin
        s_wvalid <= vld;
        s_wdata  <= v;
        s_wstrb  <= v[63:56] ^ v[7:0];
        s_wlast  <= last;
      end
      ch_r: begin
        m_rvalid <= vld;
        m_rid    <= v[3:0];
        m_rdata  <= ~v;
        m_rresp  <= v[9:8];
        m_rlast  <= last;
      end
      default: begin
        m_bvalid <= vld;
        m_bid    <= v[11:8];
        m_bresp  <= v[1:0];
      end
    endcase
  endtask

  task automatic send_beats(input int t);
    int i;
    for (i = 0; i < t_beats[t]; i++) begin
      drive_input(t_chan[t], 1'b1, t_base[t] ^ (64'h9e37_79b9_7f4a_7c15 * i),
                  i == t_beats[t] - 1);
      @(negedge ap_clk);
      while (!in_rdy[t_chan[t]]) @(negedge ap_clk);  // transfer on the next edge
      @(posedge ap_clk);
    end
    drive_input(t_chan[t], 1'b0, '0, 1'b0);
  endtask

  // ------------------------------
  // output readies and cycle limit
  // ------------------------------
  always @(posedge ap_clk) begin
    logic [4:0] r;
    int c;
    for (c = 0; c < 5; c++) begin
      if (rdy_mode[c] == 1) begin
        lfsr = lfsr_next(lfsr);              // one step per ready bit
        r[c] = lfsr[0];
      end else begin
        r[c] = (rdy_mode[c] == 0);
      end
    end
    m_arready <= r[ch_ar];
    m_awready <= r[ch_aw];
    m_wready  <= r[ch_w];
    s_rready  <= r[ch_r];
    s_bready  <= r[ch_b];
  end

  always @(posedge ap_clk) begin
    cycle <= cycle + 1;
    if (n_tests > 0 && cycle >= n_tests * 40) begin
      $display("timeout after %0d cycles, a channel stopped moving, %0d errors", cycle, errors);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ------------------------------
  // scoreboard sampled mid-cycle
  // ------------------------------
  always @(negedge ap_clk) begin
    int ch;
    int slot;
    logic [127:0] got;
    if (!rst_n) begin
      assert (in_rdy == 5'b0 && out_vld == 5'b0) else begin
        errors++;
        $display("a valid or ready output is high while reset is asserted");
      end
    end
    for (ch = 0; ch < 5; ch++) begin
      assert (!(wr_ptr[ch] - rd_ptr[ch] == 2 && in_rdy[ch])) else begin
        errors++;
        $display("%s input ready is high while the slice holds two beats", chan_name(ch));
      end
      if (out_vld[ch] && out_rdy[ch]) begin
        if (wr_ptr[ch] == rd_ptr[ch]) begin
          errors++;
          $display("%s output sent a beat that was never accepted", chan_name(ch));
        end else begin
          slot = rd_ptr[ch] % ring;
          got  = out_payload(ch);
          compared++;
          assert (got == exp_val[ch][slot]) else begin
            errors++;
            $display("FAIL %s: %s beat expected %h, actual %h", t_name[exp_tst[ch][slot]],
                     chan_name(ch), exp_val[ch][slot], got);
          end
          if (rdy_mode[ch] == 0) begin
            assert (cycle == exp_cyc[ch][slot] + 1) else begin
              errors++;
              $display("FAIL %s: %s latency expected 1, actual %0d", t_name[exp_tst[ch][slot]],
                       chan_name(ch), cycle - exp_cyc[ch][slot]);
            end
          end
          if (out_cnt[ch] == 0) first_out[ch] = cycle;
          last_out[ch] = cycle;
          out_cnt[ch]++;
          rd_ptr[ch]++;
        end
      end
      if (in_vld[ch] && in_rdy[ch]) begin
        slot = wr_ptr[ch] % ring;
        exp_val[ch][slot] = in_payload(ch);
        exp_cyc[ch][slot] = cycle;
        exp_tst[ch][slot] = t_cur;
        wr_ptr[ch]++;
      end
    end
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    int t;
    int ch;
    rst_n = 1'b0;
    {s_arvalid, s_awvalid, s_wvalid, m_rvalid, m_bvalid} = 5'b0;
    {m_arready, m_awready, m_wready, s_rready, s_bready} = 5'b0;
    {s_arid, s_araddr, s_arlen, s_arsize, s_arburst} = '0;
    {s_awid, s_awaddr, s_awlen, s_awsize, s_awburst} = '0;
    {s_wdata, s_wstrb, s_wlast} = '0;
    {m_rid, m_rdata, m_rresp, m_rlast} = '0;
    {m_bid, m_bresp} = '0;
    for (ch = 0; ch < 5; ch++) begin
      wr_ptr[ch]   = 0;
      rd_ptr[ch]   = 0;
      out_cnt[ch]  = 0;
      rdy_mode[ch] = 0;
    end
    //        name                chan   beats base                   mode
    add_test("ar_forward",       ch_ar, 6,  64'h0123_4567_89ab_cdef, 0);
    add_test("aw_forward",       ch_aw, 6,  64'hfedc_ba98_7654_3210, 0);
    add_test("w_random_stall",   ch_w,  12, 64'h5a5a_0f0f_3c3c_9696, 1);
    add_test("r_hold_stalled",   ch_r,  2,  64'h1111_2222_3333_4444, 2);
    add_test("b_random_return",  ch_b,  8,  64'h0000_0000_0000_0a5c, 1);
    add_test("w_full_rate",      ch_w,  16, 64'hdead_beef_cafe_f00d, 0);
    add_test("ar_while_r_stall", ch_ar, 4,  64'h7777_8888_9999_aaaa, 1);
    add_test("aw_while_r_stall", ch_aw, 4,  64'h2468_ace0_1357_9bdf, 1);
    add_test("r_random_return",  ch_r,  10, 64'hc0de_0000_ffff_1234, 1);

    repeat (3) @(posedge ap_clk);
    rst_n <= 1'b1;
    @(posedge ap_clk);
    @(negedge ap_clk);                     // first edge after release
    assert (in_rdy == 5'b0 && out_vld == 5'b0) else begin
      errors++;
      $display("outputs went active on the first edge after reset release");
    end
    repeat (2) @(posedge ap_clk);
    @(negedge ap_clk);
    assert (in_rdy == 5'h1f) else begin
      errors++;
      $display("FAIL reset_release: readies expected 1f, actual %h", in_rdy);
    end

    for (t = 0; t < n_tests; t++) begin
      @(posedge ap_clk);
      ch = t_chan[t];
      t_cur = t;
      if (ch == ch_r && rdy_mode[ch_r] == 2) begin
        assert (wr_ptr[ch_r] - rd_ptr[ch_r] == 2) else begin
          errors++;
          $display("r channel did not keep its stalled beats during other traffic");
        end
      end
      rdy_mode[ch] <= t_mode[t];
      out_cnt[ch] = 0;
      @(posedge ap_clk);
      send_beats(t);
      if (t_mode[t] != 2) begin
        while (wr_ptr[ch] != rd_ptr[ch]) @(posedge ap_clk);
      end
      if (t_mode[t] == 0) begin
        assert (out_cnt[ch] == t_beats[t] && last_out[ch] - first_out[ch] == t_beats[t] - 1)
        else begin
          errors++;
          $display("FAIL %s: output span expected %0d cycles, actual %0d", t_name[t],
                   t_beats[t] - 1, last_out[ch] - first_out[ch]);
        end
      end
    end

    for (ch = 0; ch < 5; ch++) begin
      assert (wr_ptr[ch] == rd_ptr[ch]) else begin
        errors++;
        $display("%s channel still holds beats at the end of the run", chan_name(ch));
      end
    end
    $display("%0d tests, %0d beats compared, %0d errors", n_tests, compared, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_axi_register_slice
